//--- hw/vdBusPkg.sv
`default_nettype none

package vdBusPkg;

  // Register offsets within the APB window
  localparam logic [15:0] regCtrl   = 16'h0000;
  localparam logic [15:0] regStatus = 16'h0004;
  localparam logic [15:0] regStart  = 16'h0008;
  localparam logic [15:0] regLines  = 16'h000C;

  // CTRL bits, both act as write pulses
  localparam int ctrlGo    = 0;
  localparam int ctrlVgRst = 1;

  // STATUS bits
  localparam int statHalt  = 0;
  localparam int statEmpty = 1;

  // Vector RAM write window, one word every 4 bytes
  localparam logic [15:0] vramBase  = 16'h4000;
  localparam int          vramWords = 4096;

endpackage

`default_nettype wire

//--- hw/vdVecPkg.sv
`default_nettype none

package vdVecPkg;

  // Field widths
  localparam int coordW = 13;
  localparam int intW   = 3;
  localparam int vaddrW = 12;

  // Opcode sits in the top bits of the first word
  localparam int opW   = 3;
  localparam int opLsb = 13;

  // Intensity sits in the top bits of the second VCTR word
  localparam int intLsb = 13;

  // Opcodes
  localparam logic [opW-1:0] opVctr = 3'd0;
  localparam logic [opW-1:0] opAbs  = 3'd1;
  localparam logic [opW-1:0] opHalt = 3'd2;

  ////////////////////////////////////////////////////////////////////////////
  // Line record passed from generator through queue to rasterizer
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [coordW-1:0] startX;
    logic [coordW-1:0] startY;
    logic [coordW-1:0] endX;
    logic [coordW-1:0] endY;
    logic [intW-1:0]   intensity;
  } lineT;

endpackage

`default_nettype wire

//--- hw/vdApbRegs.sv
`timescale 1ns/1ns
`default_nettype none

module vdApbRegs (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         PSEL,
  input  wire                         PENABLE,
  input  wire                         PWRITE,
  input  wire [15:0]                  PADDR,
  input  wire [31:0]                  PWDATA,
  output logic [31:0]                 PRDATA,
  output logic                        PREADY,
  output logic                        PSLVERR,
  input  wire                         halt,
  input  wire                         queueEmpty,
  input  wire                         lineDone,
  output logic                        vramWe,
  output logic [vdVecPkg::vaddrW-1:0] vramWaddr,
  output logic [15:0]                 vramWdata,
  output logic                        vgGo,
  output logic                        vgRst,
  output logic [vdVecPkg::vaddrW-1:0] startAddr
);

  logic        access;
  logic        isCtrl;
  logic        isStatus;
  logic        isStart;
  logic        isLines;
  logic        inVram;
  logic [15:0] vramOffset;
  logic [31:0] lineCount;

  // Zero wait states, everything happens in the access phase
  assign access = PSEL && PENABLE;
  assign PREADY = 1'b1;

  assign isCtrl   = PADDR == vdBusPkg::regCtrl;
  assign isStatus = PADDR == vdBusPkg::regStatus;
  assign isStart  = PADDR == vdBusPkg::regStart;
  assign isLines  = PADDR == vdBusPkg::regLines;

  assign vramOffset = PADDR - vdBusPkg::vramBase;
  assign inVram = (PADDR >= vdBusPkg::vramBase) && (PADDR[1:0] == 2'b00) &&
                  (32'(PADDR) < 32'(vdBusPkg::vramBase) + vdBusPkg::vramWords * 4);

  // Window is write only
  assign PSLVERR = access && (inVram ? !PWRITE : !(isCtrl || isStatus || isStart || isLines));

  assign vramWe    = access && PWRITE && inVram;
  assign vramWaddr = vramOffset[vdVecPkg::vaddrW+1:2];
  assign vramWdata = PWDATA[15:0];

  assign vgGo  = access && PWRITE && isCtrl && PWDATA[vdBusPkg::ctrlGo];
  assign vgRst = access && PWRITE && isCtrl && PWDATA[vdBusPkg::ctrlVgRst];

  always_comb begin
    PRDATA = '0;
    if (access && !PWRITE) begin
      if (isStatus) begin
        PRDATA[vdBusPkg::statHalt]  = halt;
        PRDATA[vdBusPkg::statEmpty] = queueEmpty;
      end else if (isStart) begin
        PRDATA[vdVecPkg::vaddrW-1:0] = startAddr;
      end else if (isLines) begin
        PRDATA = lineCount;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      startAddr <= '0;
    end else if (access && PWRITE && isStart) begin
      startAddr <= PWDATA[vdVecPkg::vaddrW-1:0];
    end
  end

  // Lines finished by the rasterizer
  always_ff @(posedge clk) begin
    if (rst) begin
      lineCount <= '0;
    end else if (lineDone) begin
      lineCount <= lineCount + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/vectorRam.sv
`timescale 1ns/1ns
`default_nettype none

module vectorRam #(
  parameter int ADDR_W = 12
) (
  input  wire              clk,
  input  wire              we,
  input  wire [ADDR_W-1:0] waddr,
  input  wire [15:0]       wdata,
  input  wire [ADDR_W-1:0] raddr,
  output logic [15:0]      rdata
);

  logic [15:0] store [2**ADDR_W];
  logic [15:0] readStage;

  // Host write port
  always_ff @(posedge clk) begin
    if (we) begin
      store[waddr] <= wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port with two register stages
  ////////////////////////////////////////////////////////////////////////////
  // Array output register, then the instruction register
  always_ff @(posedge clk) begin
    readStage <= store[raddr];
    rdata     <= readStage;
  end

endmodule

`default_nettype wire

//--- hw/vectorGen.sv
`timescale 1ns/1ns
`default_nettype none

module vectorGen #(
  parameter int VEC_DIV = 4
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         go,
  input  wire                         vgRst,
  input  wire [vdVecPkg::vaddrW-1:0]  startAddr,
  input  wire [15:0]                  rdData,
  input  wire                         full,
  output logic [vdVecPkg::vaddrW-1:0] rdAddr,
  output logic                        push,
  output vdVecPkg::lineT              pushLine,
  output logic                        halt
);

  localparam int         DIV_W      = $clog2(VEC_DIV + 1);
  localparam logic [1:0] FETCH_WAIT = 2'd2;

  typedef enum logic [1:0] {sHalt, sWord0, sWord1, sPush} stateT;

  stateT                       state;
  logic [DIV_W-1:0]            divCnt;
  logic                        stepEn;
  logic                        goPend;
  logic [1:0]                  waitCnt;
  logic                        fetchDone;
  logic [vdVecPkg::vaddrW-1:0] pc;
  logic [vdVecPkg::coordW-1:0] beamX;
  logic [vdVecPkg::coordW-1:0] beamY;
  logic [vdVecPkg::coordW-1:0] endX;
  logic [vdVecPkg::coordW-1:0] endY;
  logic [vdVecPkg::intW-1:0]   intensity;
  logic [15:0]                 opWord;
  vdVecPkg::lineT              lineReg;

  // Step enable, one pulse every VEC_DIV clocks
  always_ff @(posedge clk) begin
    if (rst || stepEn) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  assign stepEn    = divCnt == DIV_W'(VEC_DIV - 1);
  assign fetchDone = stepEn && (waitCnt == 2'd0);

  // Relative end point, wraps modulo 8192
  assign endX      = beamX + rdData[vdVecPkg::coordW-1:0];
  assign endY      = beamY + opWord[vdVecPkg::coordW-1:0];
  assign intensity = rdData[vdVecPkg::intLsb +: vdVecPkg::intW];

  ////////////////////////////////////////////////////////////////////////////
  // Fetch and decode FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || vgRst) begin
      state   <= sHalt;
      goPend  <= 1'b0;
      waitCnt <= '0;
      pc      <= '0;
      beamX   <= '0;
      beamY   <= '0;
    end else begin
      if (go && state == sHalt) begin
        goPend <= 1'b1;
      end
      if (stepEn && waitCnt != 2'd0) begin
        waitCnt <= waitCnt - 1'b1;
      end
      case (state)
        sHalt: begin
          if (stepEn && goPend) begin
            goPend  <= 1'b0;
            pc      <= startAddr;
            waitCnt <= FETCH_WAIT;
            state   <= sWord0;
          end
        end
        sWord0: begin
          if (fetchDone) begin
            case (rdData[vdVecPkg::opLsb +: vdVecPkg::opW])
              vdVecPkg::opVctr, vdVecPkg::opAbs: begin
                pc      <= pc + 1'b1;
                waitCnt <= FETCH_WAIT;
                state   <= sWord1;
              end
              vdVecPkg::opHalt: state <= sHalt;
              // Unknown opcodes take one word
              default: begin
                pc      <= pc + 1'b1;
                waitCnt <= FETCH_WAIT;
              end
            endcase
          end
        end
        sWord1: begin
          if (fetchDone) begin
            pc      <= pc + 1'b1;
            waitCnt <= FETCH_WAIT;
            if (opWord[vdVecPkg::opLsb +: vdVecPkg::opW] == vdVecPkg::opAbs) begin
              beamX <= rdData[vdVecPkg::coordW-1:0];
              beamY <= opWord[vdVecPkg::coordW-1:0];
              state <= sWord0;
            end else begin
              beamX <= endX;
              beamY <= endY;
              state <= (intensity != '0) ? sPush : sWord0;
            end
          end
        end
        // Next fetch is already under way while the queue is full
        sPush: begin
          if (push) begin
            state <= sWord0;
          end
        end
        default: state <= sHalt;
      endcase
    end
  end

  // First word and the finished line record
  always_ff @(posedge clk) begin
    if (state == sWord0 && fetchDone) begin
      opWord <= rdData;
    end
    if (state == sWord1 && fetchDone) begin
      lineReg.startX    <= beamX;
      lineReg.startY    <= beamY;
      lineReg.endX      <= endX;
      lineReg.endY      <= endY;
      lineReg.intensity <= intensity;
    end
  end

  assign rdAddr   = pc;
  assign push     = (state == sPush) && stepEn && !full;
  assign pushLine = lineReg;
  assign halt     = state == sHalt;

endmodule

`default_nettype wire

//--- hw/lineQueue.sv
`timescale 1ns/1ns
`default_nettype none

module lineQueue #(
  parameter int DEPTH = 4
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            push,
  input  vdVecPkg::lineT pushLine,
  input  wire            pop,
  output vdVecPkg::lineT headLine,
  output logic           full,
  output logic           empty
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  vdVecPkg::lineT   store [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             doPush;
  logic             doPop;

  assign doPush = push && !full;
  assign doPop  = pop && !empty;

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (doPush) begin
      store[wrPtr] <= pushLine;
    end
  end

  assign headLine = store[rdPtr];
  assign full     = count == CNT_W'(DEPTH);
  assign empty    = count == '0;

endmodule

`default_nettype wire

//--- hw/lineRaster.sv
`timescale 1ns/1ns
`default_nettype none

module lineRaster (
  input  wire                         clk,
  input  wire                         rst,
  input  vdVecPkg::lineT              headLine,
  input  wire                         empty,
  input  wire                         pixelReady,
  output logic                        pop,
  output logic                        pixelValid,
  output logic [vdVecPkg::coordW-1:0] pixelX,
  output logic [vdVecPkg::coordW-1:0] pixelY,
  output logic [vdVecPkg::intW-1:0]   pixelColor,
  output logic                        lineDone
);

  localparam int CW = vdVecPkg::coordW;
  // Room for 2*err over the full coordinate range
  localparam int EW = CW + 3;

  logic signed [CW:0]   diffX;
  logic signed [CW:0]   diffY;
  logic [CW:0]          absX;
  logic [CW:0]          absY;
  logic signed [EW-1:0] dx;
  logic signed [EW-1:0] dy;
  logic signed [EW-1:0] err;
  logic signed [EW-1:0] errNext;
  logic signed [EW:0]   err2;
  logic                 negX;
  logic                 negY;
  logic [CW-1:0]        endX;
  logic [CW-1:0]        endY;
  logic                 accept;
  logic                 atEnd;
  logic                 stepX;
  logic                 stepY;

  // Deltas of the line at the queue head
  assign diffX = signed'({1'b0, headLine.endX}) - signed'({1'b0, headLine.startX});
  assign diffY = signed'({1'b0, headLine.endY}) - signed'({1'b0, headLine.startY});
  assign absX  = diffX[CW] ? -diffX : diffX;
  assign absY  = diffY[CW] ? -diffY : diffY;

  // Idle whenever no pixel is on offer
  assign pop      = !pixelValid && !empty;
  assign accept   = pixelValid && pixelReady;
  assign atEnd    = (pixelX == endX) && (pixelY == endY);
  assign lineDone = accept && atEnd;

  ////////////////////////////////////////////////////////////////////////////
  // Combined-error step rule
  ////////////////////////////////////////////////////////////////////////////
  assign err2  = {err, 1'b0};
  assign stepX = err2 > -dy;
  assign stepY = err2 < dx;

  always_comb begin
    errNext = err;
    if (stepX) begin
      errNext = errNext - dy;
    end
    if (stepY) begin
      errNext = errNext + dx;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pixelValid <= 1'b0;
    end else if (pop) begin
      pixelValid <= 1'b1;
    end else if (lineDone) begin
      pixelValid <= 1'b0;
    end
  end

  // Position only moves on an accepted pixel
  always_ff @(posedge clk) begin
    if (pop) begin
      pixelX     <= headLine.startX;
      pixelY     <= headLine.startY;
      pixelColor <= headLine.intensity;
      endX       <= headLine.endX;
      endY       <= headLine.endY;
      negX       <= diffX[CW];
      negY       <= diffY[CW];
      dx         <= EW'(absX);
      dy         <= EW'(absY);
      err        <= EW'(absX) - EW'(absY);
    end else if (accept && !atEnd) begin
      if (stepX) begin
        pixelX <= negX ? pixelX - 1'b1 : pixelX + 1'b1;
      end
      if (stepY) begin
        pixelY <= negY ? pixelY - 1'b1 : pixelY + 1'b1;
      end
      err <= errNext;
    end
  end

endmodule

`default_nettype wire

//--- hw/vectorDisplay.sv
`timescale 1ns/1ns
`default_nettype none

module vectorDisplay #(
  parameter int VEC_DIV     = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         PSEL,
  input  wire                         PENABLE,
  input  wire                         PWRITE,
  input  wire [15:0]                  PADDR,
  input  wire [31:0]                  PWDATA,
  output logic [31:0]                 PRDATA,
  output logic                        PREADY,
  output logic                        PSLVERR,
  input  wire                         pixelReady,
  output logic                        pixelValid,
  output logic [vdVecPkg::coordW-1:0] pixelX,
  output logic [vdVecPkg::coordW-1:0] pixelY,
  output logic [vdVecPkg::intW-1:0]   pixelColor
);

  logic                        vramWe;
  logic [vdVecPkg::vaddrW-1:0] vramWaddr;
  logic [15:0]                 vramWdata;
  logic [vdVecPkg::vaddrW-1:0] rdAddr;
  logic [15:0]                 rdData;
  logic                        vgGo;
  logic                        vgRst;
  logic [vdVecPkg::vaddrW-1:0] startAddr;
  logic                        halt;
  logic                        push;
  logic                        pop;
  logic                        full;
  logic                        empty;
  logic                        lineDone;
  vdVecPkg::lineT              pushLine;
  vdVecPkg::lineT              headLine;

  ////////////////////////////////////////////////////////////////////////////
  // Host side
  ////////////////////////////////////////////////////////////////////////////
  vdApbRegs regs0 (
    .clk        (clk),
    .rst        (rst),
    .PSEL       (PSEL),
    .PENABLE    (PENABLE),
    .PWRITE     (PWRITE),
    .PADDR      (PADDR),
    .PWDATA     (PWDATA),
    .PRDATA     (PRDATA),
    .PREADY     (PREADY),
    .PSLVERR    (PSLVERR),
    .halt       (halt),
    .queueEmpty (empty),
    .lineDone   (lineDone),
    .vramWe     (vramWe),
    .vramWaddr  (vramWaddr),
    .vramWdata  (vramWdata),
    .vgGo       (vgGo),
    .vgRst      (vgRst),
    .startAddr  (startAddr)
  );

  vectorRam #(
    .ADDR_W (vdVecPkg::vaddrW)
  ) vram0 (
    .clk   (clk),
    .we    (vramWe),
    .waddr (vramWaddr),
    .wdata (vramWdata),
    .raddr (rdAddr),
    .rdata (rdData)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Drawing pipeline
  ////////////////////////////////////////////////////////////////////////////
  vectorGen #(
    .VEC_DIV (VEC_DIV)
  ) gen0 (
    .clk       (clk),
    .rst       (rst),
    .go        (vgGo),
    .vgRst     (vgRst),
    .startAddr (startAddr),
    .rdData    (rdData),
    .full      (full),
    .rdAddr    (rdAddr),
    .push      (push),
    .pushLine  (pushLine),
    .halt      (halt)
  );

  lineQueue #(
    .DEPTH (QUEUE_DEPTH)
  ) queue0 (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .pushLine (pushLine),
    .pop      (pop),
    .headLine (headLine),
    .full     (full),
    .empty    (empty)
  );

  lineRaster raster0 (
    .clk        (clk),
    .rst        (rst),
    .headLine   (headLine),
    .empty      (empty),
    .pixelReady (pixelReady),
    .pop        (pop),
    .pixelValid (pixelValid),
    .pixelX     (pixelX),
    .pixelY     (pixelY),
    .pixelColor (pixelColor),
    .lineDone   (lineDone)
  );

endmodule

`default_nettype wire

//--- sim/vectorDisplay_sva.sv
`timescale 1ns/1ns
`default_nettype none

module vectorDisplaySva (
  input wire                        clk,
  input wire                        rst,
  input wire                        pixelValid,
  input wire                        pixelReady,
  input wire [vdVecPkg::coordW-1:0] pixelX,
  input wire [vdVecPkg::coordW-1:0] pixelY,
  input wire [vdVecPkg::intW-1:0]   pixelColor,
  input wire                        push,
  input wire                        full,
  input wire                        pop,
  input wire                        empty
);

  // Number of assertion failures so far
  int errCount = 0;

  // Offered pixel holds until it is taken
  pixelHold: assert property (@(posedge clk) disable iff (rst)
    pixelValid && !pixelReady |=> pixelValid && $stable(pixelX) && $stable(pixelY) &&
                                  $stable(pixelColor))
  else begin
    $error("pixel outputs changed while stalled");
    errCount++;
  end

  // Queue flags only move on a push or a pop
  queueSteady: assert property (@(posedge clk) disable iff (rst)
    !push && !pop |=> $stable(full) && $stable(empty))
  else begin
    $error("line queue flags changed with no push or pop");
    errCount++;
  end

  // A pushed line is held in the queue
  pushTaken: assert property (@(posedge clk) disable iff (rst) push |=> !empty)
  else begin
    $error("line queue is empty right after a push");
    errCount++;
  end

  validKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(pixelValid))
  else begin
    $error("pixelValid is unknown");
    errCount++;
  end

endmodule

`default_nettype wire

//--- sim/vectorDisplayTb.sv
`timescale 1ns/1ns
`default_nettype none

module vectorDisplayTb;

  localparam int VEC_DIV      = 4;
  localparam int QUEUE_DEPTH  = 4;
  localparam int CLK_PERIOD   = 8;
  localparam int RST_CYCLES   = 16;
  // Rough pixel total over all tests
  localparam int PIXEL_BUDGET = 2500;
  localparam int TIMEOUT_NS   = (PIXEL_BUDGET * VEC_DIV * 4 + 20000) * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'hd707d253;

  typedef logic [vdVecPkg::coordW-1:0] coordT;
  typedef logic [vdVecPkg::intW-1:0]   colorT;

  logic        clk;
  logic        rst;
  logic        PSEL;
  logic        PENABLE;
  logic        PWRITE;
  logic [15:0] PADDR;
  logic [31:0] PWDATA;
  logic [31:0] PRDATA;
  logic        PREADY;
  logic        PSLVERR;
  logic        pixelReady;
  logic        pixelValid;
  coordT       pixelX;
  coordT       pixelY;
  colorT       pixelColor;

  // Reference pixels still to come, and pixel count per queued line
  coordT       expX[$];
  coordT       expY[$];
  colorT       expC[$];
  int          linePix[$];
  int          listPtr;
  int          beamX;
  int          beamY;
  int          expLines;
  logic [31:0] rngReady;
  logic [31:0] rngList;
  bit          randomReady;
  bit          sawFull;

  vectorDisplay #(
    .VEC_DIV     (VEC_DIV),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) dut0 (
    .clk        (clk),
    .rst        (rst),
    .PSEL       (PSEL),
    .PENABLE    (PENABLE),
    .PWRITE     (PWRITE),
    .PADDR      (PADDR),
    .PWDATA     (PWDATA),
    .PRDATA     (PRDATA),
    .PREADY     (PREADY),
    .PSLVERR    (PSLVERR),
    .pixelReady (pixelReady),
    .pixelValid (pixelValid),
    .pixelX     (pixelX),
    .pixelY     (pixelY),
    .pixelColor (pixelColor)
  );

  bind vectorDisplay vectorDisplaySva sva0 (
    .clk        (clk),
    .rst        (rst),
    .pixelValid (pixelValid),
    .pixelReady (pixelReady),
    .pixelX     (pixelX),
    .pixelY     (pixelY),
    .pixelColor (pixelColor),
    .push       (push),
    .full       (full),
    .pop        (pop),
    .empty      (empty)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcgStep(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Ready is either held high or follows the LCG
  always @(posedge clk) begin
    rngReady   <= lcgStep(rngReady);
    pixelReady <= randomReady ? rngReady[16] : 1'b1;
  end

  always @(negedge clk) begin
    if (dut0.full) begin
      sawFull = 1'b1;
    end
  end

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped on first error");
  endtask

  always @(negedge clk) begin
    if (dut0.sva0.errCount != 0) begin
      failRun("a bound assertion on the DUT failed");
    end
  end

  task automatic checkCoord(input string name, input coordT exp, input coordT act);
    if (act !== exp) begin
      failRun($sformatf("ERROR at %0t ns: %s expected %0d got %0d", $time, name, exp, act));
    end
  endtask

  task automatic checkColor(input string name, input colorT exp, input colorT act);
    if (act !== exp) begin
      failRun($sformatf("ERROR at %0t ns: %s expected %0d got %0d", $time, name, exp, act));
    end
  endtask

  task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      failRun($sformatf("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic checkErr(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      failRun($sformatf("ERROR at %0t ns: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////////////////////
  task automatic apbWrite(input logic [15:0] addr, input logic [31:0] data, output logic err);
    @(posedge clk);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b1;
    PADDR   <= addr;
    PWDATA  <= data;
    @(posedge clk);
    PENABLE <= 1'b1;
    @(negedge clk);
    // Zero wait states
    checkErr("PREADY", 1'b1, PREADY);
    err = PSLVERR;
    @(posedge clk);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  task automatic apbRead(input logic [15:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
    PADDR   <= addr;
    @(posedge clk);
    PENABLE <= 1'b1;
    @(negedge clk);
    checkErr("PREADY", 1'b1, PREADY);
    data = PRDATA;
    err  = PSLVERR;
    @(posedge clk);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bresenham reference and display list builder
  ////////////////////////////////////////////////////////////////////////////
  task automatic refLine(input vdVecPkg::lineT ln);
    int x;
    int y;
    int x1;
    int y1;
    int dx;
    int dy;
    int sx;
    int sy;
    int err;
    int e2;
    int n;
    bit done;
    x  = int'(ln.startX);
    y  = int'(ln.startY);
    x1 = int'(ln.endX);
    y1 = int'(ln.endY);
    dx = (x1 > x) ? x1 - x : x - x1;
    dy = (y1 > y) ? y1 - y : y - y1;
    sx = (x1 >= x) ? 1 : -1;
    sy = (y1 >= y) ? 1 : -1;
    err  = dx - dy;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      expX.push_back(coordT'(x));
      expY.push_back(coordT'(y));
      expC.push_back(ln.intensity);
      n++;
      if (x == x1 && y == y1) begin
        done = 1'b1;
      end else begin
        e2 = 2 * err;
        if (e2 > -dy) begin
          err -= dy;
          x   += sx;
        end
        if (e2 < dx) begin
          err += dx;
          y   += sy;
        end
      end
    end
    linePix.push_back(n);
  endtask

  task automatic putWord(input logic [15:0] word);
    logic err;
    apbWrite(vdBusPkg::vramBase + 16'(listPtr * 4), {16'h0000, word}, err);
    checkErr("PSLVERR", 1'b0, err);
    listPtr++;
  endtask

  task automatic putAbs(input int x, input int y);
    putWord({vdVecPkg::opAbs, coordT'(y)});
    putWord({3'b000, coordT'(x)});
    beamX = x;
    beamY = y;
  endtask

  // End point wraps modulo 8192 through the 13-bit casts
  task automatic putVctr(input int dx, input int dy, input int inten);
    vdVecPkg::lineT ln;
    ln.startX    = coordT'(beamX);
    ln.startY    = coordT'(beamY);
    ln.endX      = coordT'(beamX + dx);
    ln.endY      = coordT'(beamY + dy);
    ln.intensity = colorT'(inten);
    putWord({vdVecPkg::opVctr, coordT'(dy)});
    putWord({colorT'(inten), coordT'(dx)});
    if (inten != 0) begin
      refLine(ln);
      expLines++;
    end
    beamX = int'(ln.endX);
    beamY = int'(ln.endY);
  endtask

  task automatic putHalt();
    putWord({vdVecPkg::opHalt, coordT'(0)});
  endtask

  // Pixel collector compares every transfer against the reference
  always @(negedge clk) begin
    if (!rst && pixelValid && pixelReady) begin
      if (expX.size() == 0) begin
        failRun("a pixel arrived while no pixel was expected");
      end else begin
        checkCoord("pixelX", expX.pop_front(), pixelX);
        checkCoord("pixelY", expY.pop_front(), pixelY);
        checkColor("pixelColor", expC.pop_front(), pixelColor);
      end
    end
  end

  task automatic waitIdle(input bit allDrawn);
    logic [31:0] status;
    logic        err;
    bit          idle;
    idle = 1'b0;
    while (!idle) begin
      apbRead(vdBusPkg::regStatus, status, err);
      @(negedge clk);
      idle = status[vdBusPkg::statHalt] && status[vdBusPkg::statEmpty] && !pixelValid &&
             (!allDrawn || expX.size() == 0);
    end
  endtask

  task automatic runList(input int startWord);
    logic [31:0] data;
    logic        err;
    apbWrite(vdBusPkg::regStart, 32'(startWord), err);
    apbWrite(vdBusPkg::regCtrl, 32'd1 << vdBusPkg::ctrlGo, err);
    checkErr("PSLVERR", 1'b0, err);
    waitIdle(1'b1);
    apbRead(vdBusPkg::regStatus, data, err);
    checkWord("STATUS", (32'd1 << vdBusPkg::statHalt) | (32'd1 << vdBusPkg::statEmpty), data);
    apbRead(vdBusPkg::regLines, data, err);
    checkWord("LINES", 32'(expLines), data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic testRegisters();
    logic [31:0] data;
    logic        err;
    apbRead(vdBusPkg::regStatus, data, err);
    checkErr("PSLVERR", 1'b0, err);
    checkWord("STATUS", (32'd1 << vdBusPkg::statHalt) | (32'd1 << vdBusPkg::statEmpty), data);
    apbRead(vdBusPkg::regLines, data, err);
    checkWord("LINES", 32'd0, data);
    apbWrite(vdBusPkg::regStart, 32'h0000_0abc, err);
    checkErr("PSLVERR", 1'b0, err);
    apbRead(vdBusPkg::regStart, data, err);
    checkWord("START", 32'h0000_0abc, data);
    apbRead(vdBusPkg::vramBase + 16'h0010, data, err);
    checkErr("PSLVERR", 1'b1, err);
    apbWrite(16'h0020, 32'h0000_0001, err);
    checkErr("PSLVERR", 1'b1, err);
    apbRead(16'h2000, data, err);
    checkErr("PSLVERR", 1'b1, err);
  endtask

  task automatic testSingleVector();
    listPtr = 0;
    putAbs(100, 200);
    putVctr(13, -5, 5);
    putHalt();
    runList(0);
  endtask

  task automatic testOctants();
    int octDx[8] = '{20, 7, -7, -20, -20, -7, 7, 20};
    int octDy[8] = '{7, 20, 20, 7, -7, -20, -20, -7};
    listPtr = 64;
    putAbs(1000, 1000);
    for (int k = 0; k < 8; k++) begin
      putVctr(octDx[k], octDy[k], k % 7 + 1);
      // Blank move in the middle of the chain
      if (k == 3) begin
        putVctr(30, 5, 0);
      end
    end
    putHalt();
    runList(64);
  endtask

  // List LCG restarts from the seed so each call builds the same list
  task automatic buildShortList(input int base);
    int dx;
    int dy;
    rngList = SEED;
    listPtr = base;
    putAbs(2000, 2000);
    repeat (16) begin
      rngList = lcgStep(rngList);
      dx = int'(rngList[23:16]) % 97 - 48;
      dy = int'(rngList[15:8]) % 97 - 48;
      putVctr(dx, dy, int'(rngList[30:28]) % 7 + 1);
    end
    putHalt();
  endtask

  task automatic testStalls();
    buildShortList(128);
    runList(128);
    sawFull = 1'b0;
    randomReady <= 1'b1;
    buildShortList(128);
    runList(128);
    randomReady <= 1'b0;
    if (!sawFull) begin
      failRun("the line queue never filled while pixelReady stalled");
    end
  endtask

  task automatic testStartAndReset();
    logic [31:0] data;
    logic [31:0] linesBefore;
    logic        err;
    int          linesRun;
    int          remaining;
    int          savedLines;
    listPtr = 512;
    putAbs(300, 300);
    putVctr(10, 10, 3);
    putHalt();
    runList(512);

    // Long list so that vgRst lands while lines are still queued
    listPtr    = 1024;
    savedLines = expLines;
    linePix.delete();
    putAbs(500, 500);
    for (int i = 0; i < 12; i++) begin
      putVctr((i % 2 == 1) ? -59 : 59, 7, 7 - i % 6);
    end
    putHalt();
    apbRead(vdBusPkg::regLines, linesBefore, err);
    apbWrite(vdBusPkg::regStart, 32'd1024, err);
    apbWrite(vdBusPkg::regCtrl, 32'd1 << vdBusPkg::ctrlGo, err);
    data = linesBefore;
    while (data < linesBefore + 2) begin
      apbRead(vdBusPkg::regLines, data, err);
    end
    apbWrite(vdBusPkg::regCtrl, 32'd1 << vdBusPkg::ctrlVgRst, err);
    waitIdle(1'b0);
    apbRead(vdBusPkg::regLines, data, err);
    linesRun = int'(data - linesBefore);
    if (linesRun < 2 || linesRun >= 12) begin
      failRun("vgRst did not stop the generator part way through the list");
    end
    // Lines never queued leave their pixels unused
    remaining = 0;
    for (int i = linesRun; i < 12; i++) begin
      remaining += linePix[i];
    end
    checkWord("pixels left after vgRst", 32'(remaining), 32'(expX.size()));
    expX.delete();
    expY.delete();
    expC.delete();
    expLines = savedLines + linesRun;

    // Beam is back at the origin
    listPtr = 1536;
    beamX   = 0;
    beamY   = 0;
    putVctr(6, 4, 2);
    putHalt();
    runList(1536);
  endtask

  initial begin
    rst         <= 1'b1;
    PSEL        <= 1'b0;
    PENABLE     <= 1'b0;
    PWRITE      <= 1'b0;
    PADDR       <= '0;
    PWDATA      <= '0;
    pixelReady  <= 1'b1;
    rngReady    = SEED;
    rngList     = SEED;
    randomReady = 1'b0;
    sawFull     = 1'b0;
    listPtr     = 0;
    beamX       = 0;
    beamY       = 0;
    expLines    = 0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    testRegisters();
    testSingleVector();
    testOctants();
    testStalls();
    testStartAndReset();
    if (dut0.sva0.errCount != 0) begin
      failRun("the bound assertions reported failures");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    failRun("watchdog timeout: the tests did not finish in time");
  end

endmodule

`default_nettype wire

//--- project.f
hw/vdBusPkg.sv
hw/vdVecPkg.sv
hw/vdApbRegs.sv
hw/vectorRam.sv
hw/vectorGen.sv
hw/lineQueue.sv
hw/lineRaster.sv
hw/vectorDisplay.sv
sim/vectorDisplay_sva.sv
sim/vectorDisplayTb.sv

//--- Bender.yml
package:
  name: vector_display

sources:
  - hw/vdBusPkg.sv
  - hw/vdVecPkg.sv
  - hw/vdApbRegs.sv
  - hw/vectorRam.sv
  - hw/vectorGen.sv
  - hw/lineQueue.sv
  - hw/lineRaster.sv
  - hw/vectorDisplay.sv
  - target: simulation
    files:
      - sim/vectorDisplay_sva.sv
      - sim/vectorDisplayTb.sv
